//--- vlog.f
source/ethPkg.sv
source/switchPkg.sv
source/rxFrameParser.sv
source/forwardTable.sv
source/pairQueue.sv
source/txScheduler.sv
source/ethSwitch.sv
verif/ethSwitchProps.sv
verif/ethSwitchTb.sv

//--- Makefile
# Verilator lint and simulation of the frame switch testbench

TOP = ethSwitchTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f vlog.f --top-module $(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/ethSwitchTb.sv
// Directed testbench for the four-port frame switch; sends frames per port and checks each output
`timescale 1ns/10ps
`default_nettype none

module ethSwitchTb;

  import ethPkg::*;
  import switchPkg::*;

  localparam int FifoDepth     = 64;
  localparam int MaxFrameBytes = 40;
  localparam int PayloadBytes  = 10;   // Normal frames, 32 bytes on the wire
  localparam int ShortPayload  = 2;    // Back-pressure frames, 24 bytes
  localparam int FrameOverhead = PreambleBytes + HeaderBytes;
  localparam int ErrByte       = 25;   // Payload byte sent with RxErr
  localparam int GapCycles     = 4;    // Idle between frames on one port
  localparam int SettleCycles  = 30;   // Quiet time after the last expected byte
  localparam int NumFrames     = 14;
  localparam int FrameCycles   = 120;  // Send, delay line, delivery and settle
  localparam int TimeoutCycles = NumFrames * FrameCycles;

  localparam boardId_t  MyBoard     = 4'h3;
  localparam macAddr_t  HostMac     = 48'h02_11_22_33_44_55;  // Plain host behind Eth1
  localparam macAddr_t  UnknownMac  = 48'h02_00_00_00_00_99;
  localparam macAddr_t  PsMac       = {LabCid, PsMacMid, 4'h0, MyBoard};
  localparam macAddr_t  RtMac       = {LabCid, RtMacMid, 4'h0, MyBoard};
  localparam macAddr_t  Board5Mac   = {LabCid, PsMacMid, 4'h0, 4'h5};  // PS of another board
  localparam macAddr_t  Board5RtMac = {LabCid, RtMacMid, 4'h0, 4'h5};  // RT of that board
  localparam portMask_t ToEth1      = 4'b0001;
  localparam portMask_t ToEth2      = 4'b0010;
  localparam portMask_t ToPs        = 4'b0100;
  localparam portMask_t ToRt        = 4'b1000;

  logic       RxClk;
  logic       reset;
  portMask_t  active;
  portMask_t  ready;
  portMask_t  rxValid;
  portMask_t  rxErr;
  byte_t      rxD [NumPorts];
  portMask_t  txEn;
  portMask_t  txErr;
  byte_t      txD [NumPorts];
  logic [8:0] expQ [NumPorts][$];  // {TxErr, TxD} expected per output
  logic [8:0] gotQ [NumPorts][$];  // Same, as seen on TxEn
  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;

  ethSwitch #(
    .FifoDepth    (FifoDepth),
    .MaxFrameBytes(MaxFrameBytes)
  ) uut (
    .RxClk(RxClk), .reset(reset), .BoardId(MyBoard),
    .P0Active(active[0]), .P0Ready(ready[0]), .P0RxValid(rxValid[0]), .P0RxD(rxD[0]),
    .P0RxErr(rxErr[0]), .P0TxEn(txEn[0]), .P0TxD(txD[0]), .P0TxErr(txErr[0]),
    .P1Active(active[1]), .P1Ready(ready[1]), .P1RxValid(rxValid[1]), .P1RxD(rxD[1]),
    .P1RxErr(rxErr[1]), .P1TxEn(txEn[1]), .P1TxD(txD[1]), .P1TxErr(txErr[1]),
    .P2Active(active[2]), .P2Ready(ready[2]), .P2RxValid(rxValid[2]), .P2RxD(rxD[2]),
    .P2RxErr(rxErr[2]), .P2TxEn(txEn[2]), .P2TxD(txD[2]), .P2TxErr(txErr[2]),
    .P3Active(active[3]), .P3Ready(ready[3]), .P3RxValid(rxValid[3]), .P3RxD(rxD[3]),
    .P3RxErr(rxErr[3]), .P3TxEn(txEn[3]), .P3TxD(txD[3]), .P3TxErr(txErr[3])
  );

  initial begin
    RxClk = 1'b0;
    forever #50 RxClk = ~RxClk;  // 100 ns period
  end

  // Outputs settle well before the falling edge
  always @(negedge RxClk) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (txEn[o]) begin
        gotQ[o].push_back({txErr[o], txD[o]});
      end
    end
  end

  always @(posedge RxClk) begin
    cycles <= cycles + 1;
    if (cycles > TimeoutCycles) begin
      $display("timeout: expected frames did not arrive within %0d cycles", TimeoutCycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic checkValue(input int actual, input int expected, input string what);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Preamble, SFD, header and random payload; expected copies go to every port in expectMask
  task automatic sendFrame(input int port, input macAddr_t dest, input macAddr_t src,
                           input int payload, input int errAt, input portMask_t expectMask);
    byte_t frame [$];
    int    last;
    logic  errFlag;
    for (int k = 0; k < PreambleBytes - 1; k++) begin
      frame.push_back(8'h55);
    end
    frame.push_back(SfdByte);
    for (int k = 5; k >= 0; k--) begin
      frame.push_back(dest[8*k +: 8]);  // MSB first on the wire
    end
    for (int k = 5; k >= 0; k--) begin
      frame.push_back(src[8*k +: 8]);
    end
    frame.push_back(8'h08);  // Type IPv4
    frame.push_back(8'h00);
    for (int k = 0; k < payload; k++) begin
      frame.push_back(8'($urandom()));
    end
    last = frame.size() - 1;
    for (int o = 0; o < NumPorts; o++) begin
      if (expectMask[o]) begin
        for (int k = 0; k <= last; k++) begin
          errFlag = (k == errAt) && (k != 0) && (k != last);  // First and last hide errors
          expQ[o].push_back({errFlag, frame[k]});
        end
      end
    end
    for (int k = 0; k <= last; k++) begin
      @(posedge RxClk);
      #1;
      rxValid[port] = 1'b1;
      rxD[port]     = frame[k];
      rxErr[port]   = (k == errAt);
    end
    @(posedge RxClk);
    #1;
    rxValid[port] = 1'b0;
    rxErr[port]   = 1'b0;
    repeat (GapCycles) @(posedge RxClk);
  endtask

  // Waits for every expected byte, then compares the outputs and clears both sides
  task automatic drainAndCompare(input string step);
    logic pending;
    pending = 1'b1;
    while (pending) begin
      @(posedge RxClk);
      pending = 1'b0;
      for (int o = 0; o < NumPorts; o++) begin
        if (gotQ[o].size() < expQ[o].size()) begin
          pending = 1'b1;
        end
      end
    end
    repeat (SettleCycles) @(posedge RxClk);  // Stray bytes show up in the count
    for (int o = 0; o < NumPorts; o++) begin
      checkValue(gotQ[o].size(), expQ[o].size(), $sformatf("%s, port %0d bytes", step, o));
      for (int k = 0; k < expQ[o].size() && k < gotQ[o].size(); k++) begin
        checkValue(gotQ[o][k], expQ[o][k],
                   $sformatf("%s, port %0d byte %0d {err,data}", step, o, k));
      end
      expQ[o].delete();
      gotQ[o].delete();
    end
  endtask

  task automatic broadcastFromPs;
    sendFrame(PsPort, BroadcastMac, PsMac, PayloadBytes, -1, ToEth1 | ToEth2 | ToRt);
    drainAndCompare("broadcast");
  endtask

  task automatic fpgaUnicastAndFlood;
    sendFrame(PsPort, RtMac, PsMac, PayloadBytes, -1, ToRt);  // Primary match only
    drainAndCompare("rt unicast");
    sendFrame(RtPort, UnknownMac, RtMac, PayloadBytes, -1, ToEth1 | ToEth2);
    drainAndCompare("unknown flood");
  endtask

  task automatic hostLearning;
    sendFrame(Eth1Port, BroadcastMac, HostMac, PayloadBytes, -1, ToEth2 | ToPs | ToRt);
    drainAndCompare("host learn");
    sendFrame(RtPort, HostMac, RtMac, PayloadBytes, -1, ToEth1);
    drainAndCompare("learned host");
    @(posedge RxClk);
    #1;
    active[Eth1Port] = 1'b0;  // Link drop forgets the host
    @(posedge RxClk);
    #1;
    active[Eth1Port] = 1'b1;
    sendFrame(RtPort, HostMac, RtMac, PayloadBytes, -1, ToEth1 | ToEth2);
    drainAndCompare("host forgotten");
  endtask

  task automatic boardLearning;
    sendFrame(PsPort, Board5Mac, PsMac, PayloadBytes, -1, ToEth1 | ToEth2);  // Unclaimed board
    drainAndCompare("board unknown");
    sendFrame(Eth2Port, BroadcastMac, Board5RtMac, PayloadBytes, -1, ToEth1 | ToPs | ToRt);
    drainAndCompare("board learn");
    sendFrame(PsPort, Board5Mac, PsMac, PayloadBytes, -1, ToEth2);  // Board match, no host hit
    drainAndCompare("learned board");
  endtask

  task automatic backPressure;
    int rtFill;  // Bytes held in the PS to RT queue
    rtFill = 0;
    @(posedge RxClk);
    #1;
    ready[RtPort] = 1'b0;
    for (int n = 0; n < 3; n++) begin
      if (FifoDepth - rtFill >= MaxFrameBytes) begin  // Room at the first byte
        rtFill += FrameOverhead + ShortPayload;
        sendFrame(PsPort, RtMac, PsMac, ShortPayload, -1, ToRt);
      end else begin
        sendFrame(PsPort, RtMac, PsMac, ShortPayload, -1, '0);  // Dropped whole
      end
    end
    repeat (HeaderBytes + 2) @(posedge RxClk);  // Last frame fully through the delay line
    #1;
    ready[RtPort] = 1'b1;
    drainAndCompare("back-pressure");
  endtask

  // Eth1 starts first and is served first, PS follows unmixed with one error byte
  task automatic roundRobinAndErrors;
    fork
      sendFrame(Eth1Port, RtMac, HostMac, PayloadBytes, -1, ToRt);
      begin
        repeat (5) @(posedge RxClk);
        sendFrame(PsPort, RtMac, PsMac, PayloadBytes, ErrByte, ToRt);
      end
    join
    drainAndCompare("round-robin");
  endtask

  initial begin
    void'($urandom(32'h304f));
    reset   = 1'b1;
    active  = '1;
    ready   = '1;
    rxValid = '0;
    rxErr   = '0;
    for (int p = 0; p < NumPorts; p++) begin
      rxD[p] = '0;
    end
    repeat (2) @(posedge RxClk);
    #1;
    reset = 1'b0;
    broadcastFromPs();
    fpgaUnicastAndFlood();
    hostLearning();
    boardLearning();
    backPressure();
    roundRobinAndErrors();
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/ethSwitchProps.sv
// Transmit protocol assertions for the frame switch, attached to the top level by bind
`timescale 1ns/10ps
`default_nettype none

module ethSwitchProps (
  input wire RxClk,
  input wire reset,
  input wire P0Ready,
  input wire P1Ready,
  input wire P2Ready,
  input wire P3Ready,
  input wire P0TxEn,
  input wire P1TxEn,
  input wire P2TxEn,
  input wire P3TxEn
);

  logic [3:0] ready;
  logic [3:0] txEn;

  assign ready = {P3Ready, P2Ready, P1Ready, P0Ready};
  assign txEn  = {P3TxEn, P2TxEn, P1TxEn, P0TxEn};

  // A stalled port takes no bytes
  stallHoldsTx: assert property (@(posedge RxClk) disable iff (reset) (txEn & ~ready) == 4'b0)
    else $error("TxEn high on a port whose PortReady is low");

  // Outputs leave reset quiet
  quietAfterReset: assert property (@(posedge RxClk) reset |=> (txEn == 4'b0))
    else $error("TxEn high in the cycle after reset");

endmodule

bind ethSwitch ethSwitchProps props (
  .RxClk  (RxClk),
  .reset  (reset),
  .P0Ready(P0Ready),
  .P1Ready(P1Ready),
  .P2Ready(P2Ready),
  .P3Ready(P3Ready),
  .P0TxEn (P0TxEn),
  .P1TxEn (P1TxEn),
  .P2TxEn (P2TxEn),
  .P3TxEn (P3TxEn)
);

`default_nettype wire

//--- source/ethSwitch.sv
// Top of the four-port frame switch: parsers, forwarding table, pair queues and output schedulers
`timescale 1ns/10ps
`default_nettype none

module ethSwitch #(
  parameter int FifoDepth     = 64,  // Per pair queue, power of two
  parameter int MaxFrameBytes = 40
) (
  input  wire                   RxClk,
  input  wire                   reset,
  input  wire ethPkg::boardId_t BoardId,
  // Port 0, Eth1
  input  wire                   P0Active,
  input  wire                   P0Ready,
  input  wire                   P0RxValid,
  input  wire ethPkg::byte_t    P0RxD,
  input  wire                   P0RxErr,
  output logic                  P0TxEn,
  output ethPkg::byte_t         P0TxD,
  output logic                  P0TxErr,
  // Port 1, Eth2
  input  wire                   P1Active,
  input  wire                   P1Ready,
  input  wire                   P1RxValid,
  input  wire ethPkg::byte_t    P1RxD,
  input  wire                   P1RxErr,
  output logic                  P1TxEn,
  output ethPkg::byte_t         P1TxD,
  output logic                  P1TxErr,
  // Port 2, PS
  input  wire                   P2Active,
  input  wire                   P2Ready,
  input  wire                   P2RxValid,
  input  wire ethPkg::byte_t    P2RxD,
  input  wire                   P2RxErr,
  output logic                  P2TxEn,
  output ethPkg::byte_t         P2TxD,
  output logic                  P2TxErr,
  // Port 3, RT
  input  wire                   P3Active,
  input  wire                   P3Ready,
  input  wire                   P3RxValid,
  input  wire ethPkg::byte_t    P3RxD,
  input  wire                   P3RxErr,
  output logic                  P3TxEn,
  output ethPkg::byte_t         P3TxD,
  output logic                  P3TxErr
);

  import ethPkg::*;
  import switchPkg::*;

  portMask_t   portActive;
  portMask_t   portReady;
  portMask_t   rxValid;
  portMask_t   rxErr;
  byte_t       rxD [NumPorts];
  portMask_t   txEn;
  portMask_t   txErr;
  byte_t       txD [NumPorts];
  portMask_t   dlyValid;                        // Delayed stream per input
  byte_t       dlyByte [NumPorts];
  byteStatus_t dlyStatus [NumPorts];
  macAddr_t    destMac [NumPorts];
  macAddr_t    srcMac [NumPorts];
  portMask_t   learnStrobe;
  portMask_t   forwardMask [NumPorts];          // [in][out]
  portMask_t   pktReady [NumPorts];             // [out][in] from here on
  portMask_t   pop [NumPorts];
  byte_t       headByte [NumPorts][NumPorts];
  byteStatus_t headStatus [NumPorts][NumPorts];

  assign portActive = {P3Active, P2Active, P1Active, P0Active};
  assign portReady  = {P3Ready, P2Ready, P1Ready, P0Ready};
  assign rxValid    = {P3RxValid, P2RxValid, P1RxValid, P0RxValid};
  assign rxErr      = {P3RxErr, P2RxErr, P1RxErr, P0RxErr};
  assign rxD        = '{P0RxD, P1RxD, P2RxD, P3RxD};

  assign {P3TxEn, P2TxEn, P1TxEn, P0TxEn}     = txEn;
  assign {P3TxErr, P2TxErr, P1TxErr, P0TxErr} = txErr;
  assign P0TxD = txD[0];
  assign P1TxD = txD[1];
  assign P2TxD = txD[2];
  assign P3TxD = txD[3];

  for (genvar i = 0; i < NumPorts; i++) begin : gRx
    rxFrameParser parser (
      .RxClk        (RxClk),
      .reset        (reset),
      .RxValid      (rxValid[i]),
      .RxD          (rxD[i]),
      .RxErr        (rxErr[i]),
      .DelayedValid (dlyValid[i]),
      .DelayedByte  (dlyByte[i]),
      .DelayedStatus(dlyStatus[i]),
      .DestMac      (destMac[i]),
      .SrcMac       (srcMac[i]),
      .LearnStrobe  (learnStrobe[i])
    );
  end

  forwardTable table0 (
    .RxClk      (RxClk),
    .reset      (reset),
    .PortActive (portActive),
    .BoardId    (BoardId),
    .DestMac    (destMac),
    .SrcMac     (srcMac),
    .LearnStrobe(learnStrobe),
    .ForwardMask(forwardMask)
  );

  for (genvar i = 0; i < NumPorts; i++) begin : gIn
    for (genvar o = 0; o < NumPorts; o++) begin : gOut
      if (i == o) begin : gDiag  // No queue back to the input
        assign pktReady[o][i]   = 1'b0;
        assign headByte[o][i]   = '0;
        assign headStatus[o][i] = StatusNone;
      end else begin : gPair
        pairQueue #(
          .FifoDepth    (FifoDepth),
          .MaxFrameBytes(MaxFrameBytes)
        ) queue (
          .RxClk      (RxClk),
          .reset      (reset),
          .Forward    (forwardMask[i][o]),
          .InValid    (dlyValid[i]),
          .InByte     (dlyByte[i]),
          .InStatus   (dlyStatus[i]),
          .Pop        (pop[o][i]),
          .PacketReady(pktReady[o][i]),
          .HeadByte   (headByte[o][i]),
          .HeadStatus (headStatus[o][i])
        );
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gTx
    txScheduler sched (
      .RxClk      (RxClk),
      .reset      (reset),
      .PortReady  (portReady[o]),
      .PacketReady(pktReady[o]),
      .HeadByte   (headByte[o]),
      .HeadStatus (headStatus[o]),
      .Pop        (pop[o]),
      .TxEn       (txEn[o]),
      .TxD        (txD[o]),
      .TxErr      (txErr[o])
    );
  end

endmodule

`default_nettype wire

//--- source/txScheduler.sv
// Transmit side of one port: round-robin choice of an input queue and drive of TxEn, TxD, TxErr
`timescale 1ns/10ps
`default_nettype none

module txScheduler (
  input  wire                         RxClk,
  input  wire                         reset,
  input  wire                         PortReady,
  input  wire switchPkg::portMask_t   PacketReady,                      // Per input
  input  wire ethPkg::byte_t          HeadByte [switchPkg::NumPorts],
  input  wire switchPkg::byteStatus_t HeadStatus [switchPkg::NumPorts],
  output switchPkg::portMask_t        Pop,
  output logic                        TxEn,
  output ethPkg::byte_t               TxD,
  output logic                        TxErr
);

  import switchPkg::*;

  localparam logic [1:0] HoldoffCycles = 2'd3;  // Before the same input goes again

  portIdx_t   curIn;    // Current or most recent input
  portIdx_t   nextIn;
  logic       found;    // Some other input is ready
  logic       active;   // Grant held on curIn
  logic       sendLast;
  logic [1:0] holdoff;

  // Search starts after curIn, curIn itself is handled last
  always_comb begin
    found  = 1'b0;
    nextIn = curIn;
    for (int k = 1; k < NumPorts; k++) begin
      if (!found && PacketReady[portIdx_t'(curIn + k)]) begin
        found  = 1'b1;
        nextIn = portIdx_t'(curIn + k);
      end
    end
  end

  assign TxEn     = active && PortReady && PacketReady[curIn];  // Head byte goes out
  assign TxD      = HeadByte[curIn];
  assign TxErr    = (HeadStatus[curIn] == StatusError);
  assign Pop      = TxEn ? (portMask_t'(1) << curIn) : '0;
  assign sendLast = TxEn && (HeadStatus[curIn] == StatusLast);

  always_ff @(posedge RxClk) begin
    if (reset) begin
      curIn   <= '0;
      active  <= 1'b0;
      holdoff <= '0;
    end else if (active) begin
      if (sendLast) begin  // Release once the last byte has gone
        active  <= 1'b0;
        holdoff <= HoldoffCycles;
      end
    end else if (found) begin
      curIn  <= nextIn;
      active <= 1'b1;
    end else if (PacketReady[curIn]) begin
      if (holdoff == 2'd0) begin
        active <= 1'b1;
      end else begin
        holdoff <= holdoff - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/pairQueue.sv
// Packet-aware FIFO for one input/output pair; admits or drops each packet whole at its first byte
`timescale 1ns/10ps
`default_nettype none

module pairQueue #(
  parameter int FifoDepth     = 64,  // Entries, power of two
  parameter int MaxFrameBytes = 40   // Free space needed to admit a packet
) (
  input  wire                         RxClk,
  input  wire                         reset,
  input  wire                         Forward,      // Sampled with the first byte
  input  wire                         InValid,
  input  wire ethPkg::byte_t          InByte,
  input  wire switchPkg::byteStatus_t InStatus,
  input  wire                         Pop,
  output logic                        PacketReady,
  output ethPkg::byte_t               HeadByte,     // Fall-through head
  output switchPkg::byteStatus_t      HeadStatus
);

  import ethPkg::*;
  import switchPkg::*;

  localparam int AddrBits = $clog2(FifoDepth);

  byte_t               memByte [FifoDepth];
  byteStatus_t         memStatus [FifoDepth];
  logic [AddrBits-1:0] wrPtr;
  logic [AddrBits-1:0] rdPtr;
  logic [AddrBits:0]   count;         // Occupancy
  logic                isFirst;
  logic                isLast;
  logic                roomForFrame;
  logic                admit;         // Decision for a packet starting now
  logic                writing;       // Admitted packet still arriving
  logic                wrEn;
  logic                rdEn;

  assign isFirst      = InValid && (InStatus == StatusFirst);
  assign isLast       = InValid && (InStatus == StatusLast);
  assign roomForFrame = (FifoDepth - int'(count)) >= MaxFrameBytes;
  assign admit        = Forward && roomForFrame;

  // Guard against overrun by frames longer than the admission margin
  assign wrEn = InValid && (isFirst ? admit : writing) && (int'(count) < FifoDepth);
  assign rdEn = Pop && PacketReady;

  always_ff @(posedge RxClk) begin
    if (reset) begin
      writing <= 1'b0;
    end else if (isFirst) begin
      writing <= admit;  // Dropped packets are skipped to their end
    end else if (isLast) begin
      writing <= 1'b0;
    end
  end

  always_ff @(posedge RxClk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) begin
        wrPtr <= wrPtr + 1'b1;  // Wraps, depth is a power of two
      end
      if (rdEn) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({wrEn, rdEn})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge RxClk) begin
    if (wrEn) begin
      memByte[wrPtr]   <= InByte;
      memStatus[wrPtr] <= InStatus;
    end
  end

  assign PacketReady = (count != '0);  // Cut-through, any data is enough
  assign HeadByte    = memByte[rdPtr];
  assign HeadStatus  = memStatus[rdPtr];

endmodule

`default_nettype wire

//--- source/forwardTable.sv
// Learns hosts and FPGA boards behind the Ethernet ports and gives each input its forward mask
`timescale 1ns/10ps
`default_nettype none

module forwardTable (
  input  wire                  RxClk,
  input  wire                  reset,
  input  wire switchPkg::portMask_t PortActive,
  input  wire ethPkg::boardId_t BoardId,                      // This board
  input  wire ethPkg::macAddr_t DestMac [switchPkg::NumPorts],
  input  wire ethPkg::macAddr_t SrcMac [switchPkg::NumPorts],
  input  wire switchPkg::portMask_t LearnStrobe,
  output switchPkg::portMask_t  ForwardMask [switchPkg::NumPorts]  // [in][out]
);

  import ethPkg::*;
  import switchPkg::*;

  macAddr_t    hostMac [Eth1Port:Eth2Port];   // Learned host, broadcast when unknown
  logic [15:0] boardSet [Eth1Port:Eth2Port];  // Boards seen behind each Ethernet port
  macAddr_t    primaryMac [NumPorts];         // Per output
  logic [15:0] unclaimed;                     // Boards known on neither side and not ours

  // Learning on Eth1 and Eth2, forgotten while the link is down
  for (genvar p = Eth1Port; p <= Eth2Port; p++) begin : gLearn
    always_ff @(posedge RxClk) begin
      if (reset || !PortActive[p]) begin
        hostMac[p]  <= BroadcastMac;
        boardSet[p] <= '0;
      end else if (LearnStrobe[p]) begin
        hostMac[p] <= SrcMac[p];
        if (SrcMac[p][47:24] == LabCid) begin  // PS or RT of some board
          boardSet[p][SrcMac[p][3:0]] <= 1'b1;
        end
      end
    end
  end

  assign primaryMac[Eth1Port] = hostMac[Eth1Port];
  assign primaryMac[Eth2Port] = hostMac[Eth2Port];
  assign primaryMac[PsPort]   = {LabCid, PsMacMid, 4'h0, BoardId};
  assign primaryMac[RtPort]   = {LabCid, RtMacMid, 4'h0, BoardId};

  assign unclaimed = ~(boardSet[Eth1Port] | boardSet[Eth2Port] | (16'd1 << BoardId));

  for (genvar i = 0; i < NumPorts; i++) begin : gIn
    logic      flood;    // Broadcast or FPGA multicast
    logic      labDest;  // Destination is some FPGA
    logic      boardAny; // Board match on either Ethernet port
    portMask_t hit;      // Primary MAC match per output

    assign flood = (DestMac[i] == BroadcastMac) ||
                   ((DestMac[i][47:24] == LabMulticastCid) && (DestMac[i][7:0] == 8'hff));
    assign labDest = (DestMac[i][47:24] == LabCid);
    assign boardAny = labDest && (boardSet[Eth1Port][DestMac[i][3:0]] ||
                                  boardSet[Eth2Port][DestMac[i][3:0]] ||
                                  unclaimed[DestMac[i][3:0]]);

    for (genvar o = 0; o < NumPorts; o++) begin : gOut
      logic pass;

      assign hit[o] = (o != i) && (DestMac[i] == primaryMac[o]);

      if ((o == Eth1Port) || (o == Eth2Port)) begin : gEth
        logic boardHit;
        assign boardHit = labDest &&
                          (boardSet[o][DestMac[i][3:0]] || unclaimed[DestMac[i][3:0]]);
        // Unknown destinations flood to the Ethernet side
        assign pass = flood || hit[o] || boardHit || ((hit == '0) && !boardAny);
      end else begin : gFpga
        assign pass = flood || hit[o];
      end

      assign ForwardMask[i][o] = (o != i) && PortActive[o] && pass;  // Never back to input
    end
  end

endmodule

`default_nettype wire

//--- source/rxFrameParser.sv
// Receive side of one port: finds the SFD, captures the MAC fields and delays the stream 14 cycles
`timescale 1ns/10ps
`default_nettype none

module rxFrameParser (
  input  wire                    RxClk,
  input  wire                    reset,
  input  wire                    RxValid,
  input  wire ethPkg::byte_t     RxD,
  input  wire                    RxErr,
  output logic                   DelayedValid,
  output ethPkg::byte_t          DelayedByte,
  output switchPkg::byteStatus_t DelayedStatus,
  output ethPkg::macAddr_t       DestMac,      // Latest captured destination
  output ethPkg::macAddr_t       SrcMac,
  output logic                   LearnStrobe   // Header complete, SrcMac valid
);

  import ethPkg::*;
  import switchPkg::*;

  localparam int MacBytes      = 6;
  localparam int MacFieldBytes = 2 * MacBytes;  // Dest then source

  rxState_t             rxState;
  logic [3:0]           hdrCnt;                 // Header byte index
  logic                 hdrDone;
  byte_t                macField [MacFieldBytes];
  byte_t                dataPipe [HeaderBytes];
  logic [HeaderBytes:0] validPipe;              // Extra stage to see the edge at the output
  logic [HeaderBytes-1:0] errPipe;

  // Last header byte arriving this cycle
  assign hdrDone = (rxState == RxHeader) && RxValid && (hdrCnt == 4'(HeaderBytes - 1));

  always_ff @(posedge RxClk) begin
    if (reset) begin
      rxState <= RxIdle;
      hdrCnt  <= '0;
    end else begin
      case (rxState)
        RxIdle: begin
          hdrCnt <= '0;
          if (RxValid && (RxD == SfdByte)) begin  // Preamble content is not checked
            rxState <= RxHeader;
          end
        end
        RxHeader: begin
          if (!RxValid) begin  // Runt frame, start over
            rxState <= RxIdle;
            hdrCnt  <= '0;
          end else begin
            hdrCnt <= hdrCnt + 4'd1;
            if (hdrDone) begin
              rxState <= RxData;
            end
          end
        end
        RxData: begin
          if (!RxValid) begin
            rxState <= RxIdle;
          end
        end
        default: rxState <= RxIdle;
      endcase
    end
  end

  // MAC bytes in wire order, length/type is not kept
  always_ff @(posedge RxClk) begin
    if ((rxState == RxHeader) && RxValid && (hdrCnt < 4'(MacFieldBytes))) begin
      macField[hdrCnt] <= RxD;
    end
  end

  // 14-stage delay line, so DestMac is ready when the first byte leaves
  always_ff @(posedge RxClk) begin
    dataPipe[0] <= RxD;
    for (int k = 1; k < HeaderBytes; k++) begin
      dataPipe[k] <= dataPipe[k-1];
    end
    errPipe <= {errPipe[HeaderBytes-2:0], RxErr};
  end

  always_ff @(posedge RxClk) begin
    if (reset) begin
      validPipe <= '0;
    end else begin
      validPipe <= {validPipe[HeaderBytes-1:0], RxValid};
    end
  end

  assign DelayedValid = validPipe[HeaderBytes-1];
  assign DelayedByte  = dataPipe[HeaderBytes-1];
  assign LearnStrobe  = hdrDone;

  // Status from valid edges around the output stage
  always_comb begin
    if (!DelayedValid) begin
      DelayedStatus = StatusNone;
    end else if (!validPipe[HeaderBytes]) begin  // Gap before
      DelayedStatus = StatusFirst;
    end else if (!validPipe[HeaderBytes-2]) begin  // Gap after
      DelayedStatus = StatusLast;
    end else if (errPipe[HeaderBytes-1]) begin
      DelayedStatus = StatusError;
    end else begin
      DelayedStatus = StatusNone;
    end
  end

  always_comb begin
    for (int k = 0; k < MacBytes; k++) begin
      DestMac[47-8*k -: 8] = macField[k];
      SrcMac[47-8*k -: 8]  = macField[k+MacBytes];
    end
  end

endmodule

`default_nettype wire

//--- source/switchPkg.sv
// Port count, port roles and per-byte status codes shared by the switch queues and schedulers
`default_nettype none

package switchPkg;

  localparam int NumPorts = 4;

  // Fixed port roles
  localparam int Eth1Port = 0;
  localparam int Eth2Port = 1;
  localparam int PsPort   = 2;
  localparam int RtPort   = 3;

  typedef logic [1:0]          portIdx_t;   // Index of one port
  typedef logic [NumPorts-1:0] portMask_t;  // One bit per port

  // Status travelling beside every byte; first and last win over error
  typedef logic [1:0] byteStatus_t;
  localparam byteStatus_t StatusNone  = 2'b00;
  localparam byteStatus_t StatusFirst = 2'b01;  // First valid byte after a gap
  localparam byteStatus_t StatusLast  = 2'b10;  // Final valid byte of the frame
  localparam byteStatus_t StatusError = 2'b11;  // Any other byte received with RxErr

endpackage

`default_nettype wire

//--- source/ethPkg.sv
// Ethernet frame format, MAC address constants and receive FSM states; import where needed
`default_nettype none

package ethPkg;

  typedef logic [7:0]  byte_t;     // One byte on the port data lanes
  typedef logic [47:0] macAddr_t;  // Full MAC address, first byte on the wire in [47:40]
  typedef logic [3:0]  boardId_t;  // FPGA board id, low nibble of an FPGA MAC

  // Frame layout
  localparam int HeaderBytes   = 14;  // Dest MAC, source MAC, length/type
  localparam int PreambleBytes = 8;   // Seven 0x55 bytes plus the SFD
  localparam byte_t SfdByte    = 8'hd5;

  localparam macAddr_t BroadcastMac = 48'hffff_ffff_ffff;

  // FPGA MACs are LabCid, a 16-bit interface field, a zero nibble, then the board id
  localparam logic [23:0] LabCid = 24'hfa610e;

  // Multicast form of the company id; the low byte of such an address is all ones
  localparam logic [23:0] LabMulticastCid = LabCid | 24'h010000;

  // Middle fields that name the interface behind an FPGA MAC
  localparam logic [15:0] PsMacMid = 16'h0300;  // Processor side
  localparam logic [15:0] RtMacMid = 16'h1394;  // Real-time side

  // Receive FSM of the frame parser
  typedef enum logic [1:0] {
    RxIdle,    // Waiting for the SFD
    RxHeader,  // Collecting the 14 header bytes
    RxData     // Payload until valid drops
  } rxState_t;

endpackage

`default_nettype wire
